//--- common/lic_pkg.sv
// ####################################################################
// lic_pkg: widths, op codes, FSM states and bus structs shared by
// the issue stage, the execute units and write-back
// ####################################################################

`default_nettype none

package lic_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_REGS    = 32;
    localparam int IMM_W       = 12;
    localparam int N_UNITS     = 4;
    localparam int ITER_CYCLES = 32;

    typedef logic [XLEN-1:0]                xlen_t;
    typedef logic [$clog2(NUM_REGS)-1:0]    reg_addr_t;
    typedef logic [IMM_W-1:0]               imm_t;
    typedef logic [$clog2(N_UNITS)-1:0]     unit_id_t;
    typedef logic [N_UNITS-1:0]             unit_mask_t;
    typedef logic [$clog2(ITER_CYCLES)-1:0] iter_cnt_t;

    typedef enum logic [1:0] {
        OP_ADDI,
        OP_MUL,
        OP_DIVU,
        OP_REMU
    } lic_op_e;

    typedef enum logic [1:0] {
        U_IDLE,
        U_BUSY,
        U_DONE
    } unit_state_e;

    // pre-decoded instruction from the issuer
    typedef struct packed {
        lic_op_e   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t      imm;
    } issue_req_t;

    // operands already read, sent to one unit
    typedef struct packed {
        lic_op_e   op;
        reg_addr_t rd;
        xlen_t     opa;
        xlen_t     opb;
    } dispatch_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
        unit_id_t  unit_id;
    } wb_t;

endpackage

`default_nettype wire

//--- issue/gpr.sv
// ####################################################################
// gpr: 32 x 32-bit register file, two async read ports, one write
// port, x0 reads as zero
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module gpr (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               we_i,
    input  lic_pkg::reg_addr_t waddr_i,
    input  lic_pkg::xlen_t     wdata_i,
    input  lic_pkg::reg_addr_t raddr1_i,
    input  lic_pkg::reg_addr_t raddr2_i,
    output lic_pkg::xlen_t     rdata1_o,
    output lic_pkg::xlen_t     rdata2_o
);
    import lic_pkg::*;

    xlen_t regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- issue/issue_ctrl.sv
// ####################################################################
// issue_ctrl: pending-register scoreboard and unit credits, accepts
// one instruction when it is hazard free and dispatches it to the
// lowest unit holding a credit
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module issue_ctrl (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  lic_pkg::issue_req_t issue_i,
    output logic                issue_ready_o,
    output lic_pkg::reg_addr_t  rs1_addr_o,
    output lic_pkg::reg_addr_t  rs2_addr_o,
    input  lic_pkg::xlen_t      rs1_data_i,
    input  lic_pkg::xlen_t      rs2_data_i,
    input  lic_pkg::unit_mask_t credit_return_i,
    input  logic                commit_valid_i,
    input  lic_pkg::reg_addr_t  commit_rd_i,
    output lic_pkg::unit_mask_t dispatch_valid_o,
    output lic_pkg::dispatch_t  dispatch_o
);
    import lic_pkg::*;

    // set while a result for that register is in flight
    logic [NUM_REGS-1:0] pending_q;
    logic [NUM_REGS-1:0] pending_d;
    // one bit per unit, high when the unit is free to take work
    unit_mask_t          credit_q;
    unit_mask_t          credit_d;
    unit_mask_t          dispatch_valid_q;
    dispatch_t           dispatch_q;

    logic                rs2_used;
    logic                hazard;
    logic                accept;
    unit_mask_t          spend;
    xlen_t               opb;

    assign rs1_addr_o = issue_i.rs1;
    assign rs2_addr_o = issue_i.rs2;

    // addi has no rs2
    assign rs2_used = (issue_i.op != OP_ADDI);

    // rd is checked too, so two writes to one register never overlap
    assign hazard = pending_q[issue_i.rs1]
                  | (rs2_used & pending_q[issue_i.rs2])
                  | pending_q[issue_i.rd];

    assign issue_ready_o = ~hazard & (|credit_q);
    assign accept        = issue_valid_i & issue_ready_o;

    // isolate the lowest set credit bit
    assign spend = credit_q & (~credit_q + unit_mask_t'(1));

    assign opb = rs2_used ? rs2_data_i : {{(XLEN-IMM_W){issue_i.imm[IMM_W-1]}}, issue_i.imm};

    always_comb begin
        pending_d = pending_q;
        if (commit_valid_i) begin
            pending_d[commit_rd_i] = 1'b0;
        end
        if (accept) begin
            pending_d[issue_i.rd] = 1'b1;
        end
        // x0 never waits on anything
        pending_d[0] = 1'b0;
    end

    // a returned credit always belongs to a unit that was not spendable
    assign credit_d = (credit_q & ~(accept ? spend : unit_mask_t'(0))) | credit_return_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q        <= '0;
            credit_q         <= '1;
            dispatch_valid_q <= '0;
        end else begin
            pending_q        <= pending_d;
            credit_q         <= credit_d;
            dispatch_valid_q <= accept ? spend : unit_mask_t'(0);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch_q.op  <= issue_i.op;
            dispatch_q.rd  <= issue_i.rd;
            dispatch_q.opa <= rs1_data_i;
            dispatch_q.opb <= opb;
        end
    end

    assign dispatch_valid_o = dispatch_valid_q;
    assign dispatch_o       = dispatch_q;

endmodule

`default_nettype wire

//--- exec/exec_unit.sv
// ####################################################################
// exec_unit: one execute slot; addi in a single step, mul as a
// 32-step shift-add, divu/remu as a 32-step restoring divide.
// Holds its result until write-back grants it.
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module exec_unit #(
    parameter lic_pkg::unit_id_t UNIT_ID = '0
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  lic_pkg::dispatch_t op_i,
    input  logic               grant_i,
    output logic               done_o,
    output lic_pkg::wb_t       result_o
);
    import lic_pkg::*;

    unit_state_e   state_q;
    iter_cnt_t     cnt_q;
    lic_op_e       op_q;
    reg_addr_t     rd_q;
    // product, or partial remainder
    xlen_t         acc_q;
    // multiplicand, or dividend turning into quotient
    xlen_t         sh_q;
    // multiplier, or divisor
    xlen_t         opb_q;
    xlen_t         res_q;

    xlen_t         acc_nx;
    xlen_t         sh_nx;
    xlen_t         opb_nx;
    logic [XLEN:0]   rem_sh;
    logic [XLEN+1:0] trial;
    logic          last_step;

    assign last_step = (cnt_q == iter_cnt_t'(ITER_CYCLES - 1));

    // one iteration of whichever algorithm op_q selects
    always_comb begin
        acc_nx = acc_q;
        sh_nx  = sh_q;
        opb_nx = opb_q;
        rem_sh = {acc_q, sh_q[XLEN-1]};
        trial  = {1'b0, rem_sh} - {2'b00, opb_q};
        if (op_q == OP_MUL) begin
            if (opb_q[0]) begin
                acc_nx = acc_q + sh_q;
            end
            sh_nx  = sh_q << 1;
            opb_nx = opb_q >> 1;
        end else if (trial[XLEN+1]) begin
            // divisor did not fit, keep the shifted remainder
            acc_nx = rem_sh[XLEN-1:0];
            sh_nx  = {sh_q[XLEN-2:0], 1'b0};
        end else begin
            // a zero divisor always lands here: quotient all ones, remainder the dividend
            acc_nx = trial[XLEN-1:0];
            sh_nx  = {sh_q[XLEN-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= U_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                U_IDLE: begin
                    if (start_i) begin
                        state_q <= (op_i.op == OP_ADDI) ? U_DONE : U_BUSY;
                        cnt_q   <= '0;
                    end
                end
                U_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= U_DONE;
                    end
                end
                U_DONE: begin
                    if (grant_i) begin
                        state_q <= U_IDLE;
                    end
                end
                default: state_q <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == U_IDLE) && start_i) begin
            op_q  <= op_i.op;
            rd_q  <= op_i.rd;
            res_q <= op_i.opa + op_i.opb;
            acc_q <= '0;
            sh_q  <= op_i.opa;
            opb_q <= op_i.opb;
        end else if (state_q == U_BUSY) begin
            acc_q <= acc_nx;
            sh_q  <= sh_nx;
            opb_q <= opb_nx;
            if (last_step) begin
                res_q <= (op_q == OP_DIVU) ? sh_nx : acc_nx;
            end
        end
    end

    assign done_o           = (state_q == U_DONE);
    assign result_o.rd      = rd_q;
    assign result_o.data    = res_q;
    assign result_o.unit_id = UNIT_ID;

endmodule

`default_nettype wire

//--- writeback/wb_arbiter.sv
// ####################################################################
// wb_arbiter: round-robin pick of one finished unit per cycle,
// returns its credit and registers the result as the commit
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  logic                clk,
    input  logic                rst_n_i,
    input  lic_pkg::unit_mask_t done_i,
    input  lic_pkg::wb_t        results_i [lic_pkg::N_UNITS],
    output lic_pkg::unit_mask_t grant_o,
    output logic                wb_valid_o,
    output lic_pkg::wb_t        wb_o
);
    import lic_pkg::*;

    // unit with highest priority this cycle
    unit_id_t ptr_q;
    unit_id_t sel;
    logic     found;

    // scan from the pointer, wrapping around the units
    always_comb begin
        unit_id_t idx;
        grant_o = '0;
        sel     = ptr_q;
        found   = 1'b0;
        for (int i = 0; i < N_UNITS; i++) begin
            idx = unit_id_t'((int'(ptr_q) + i) % N_UNITS);
            if (!found && done_i[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
        if (found) begin
            grant_o[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ptr_q      <= '0;
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= found;
            // winner drops to lowest priority
            if (found) begin
                ptr_q <= unit_id_t'((int'(sel) + 1) % N_UNITS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            wb_o <= results_i[sel];
        end
    end

endmodule

`default_nettype wire

//--- verilog/lic_top.sv
// ####################################################################
// lic_top: issue stage, register file, execute unit array and
// write-back arbiter for out-of-order long instructions
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module lic_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  lic_pkg::issue_req_t issue_i,
    output logic                issue_ready_o,
    output logic                wb_valid_o,
    output lic_pkg::wb_t        wb_o
);
    import lic_pkg::*;

    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    unit_mask_t dispatch_valid;
    dispatch_t  dispatch;
    unit_mask_t done;
    unit_mask_t grant;
    wb_t        results [N_UNITS];

    issue_ctrl u_issue_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_i         (issue_i),
        .issue_ready_o   (issue_ready_o),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .credit_return_i (grant),
        .commit_valid_i  (wb_valid_o),
        .commit_rd_i     (wb_o.rd),
        .dispatch_valid_o(dispatch_valid),
        .dispatch_o      (dispatch)
    );

    // committed results land here in the same edge the pending bit clears
    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_valid_o),
        .waddr_i (wb_o.rd),
        .wdata_i (wb_o.data),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    for (genvar i = 0; i < N_UNITS; i++) begin : g_unit
        exec_unit #(
            .UNIT_ID(unit_id_t'(i))
        ) u_exec_unit (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .start_i (dispatch_valid[i]),
            .op_i    (dispatch),
            .grant_i (grant[i]),
            .done_o  (done[i]),
            .result_o(results[i])
        );
    end

    wb_arbiter u_wb_arbiter (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .done_i    (done),
        .results_i (results),
        .grant_o   (grant),
        .wb_valid_o(wb_valid_o),
        .wb_o      (wb_o)
    );

endmodule

`default_nettype wire

//--- tests/lic_props.sv
// ####################################################################
// lic_props: concurrent checks on the credit and dispatch logic of
// issue_ctrl, bound into every instance
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module lic_props (
    input  logic                clk,
    input  logic                rst_n_i,
    input  lic_pkg::unit_mask_t dispatch_valid_i,
    input  lic_pkg::unit_mask_t credit_i,
    input  lic_pkg::unit_mask_t credit_return_i
);
    import lic_pkg::*;

    // at most one unit started per cycle
    a_dispatch_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dispatch_valid_i != '0) |-> $onehot(dispatch_valid_i))
        else $error("dispatch_valid not one-hot: %b", dispatch_valid_i);

    // dispatch follows acceptance by one cycle, so look at the credits then
    a_dispatch_has_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dispatch_valid_i != '0) |-> ((dispatch_valid_i & ~$past(credit_i)) == '0))
        else $error("dispatch to a unit without credit: %b", dispatch_valid_i);

    a_no_double_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        (credit_return_i & credit_i) == '0)
        else $error("credit returned to a unit that holds one: %b", credit_return_i);

endmodule

bind issue_ctrl lic_props i_props (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .dispatch_valid_i(dispatch_valid_o),
    .credit_i        (credit_q),
    .credit_return_i (credit_return_i)
);

`default_nettype wire

//--- tests/tb_lic.sv
// ####################################################################
// tb_lic: drives lic_top with addi loads, random long ops, zero
// divisors, a dependent chain and x0 writes, and compares each
// write-back with a sequential reference model
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module tb_lic;
    import lic_pkg::*;

    localparam int          N_LOAD      = 16;
    localparam int          N_RAND      = 40;
    localparam int          N_CHAIN     = 8;
    localparam int          N_INSTR     = N_LOAD + N_RAND + 2 + N_CHAIN + 3;
    localparam int          CYCLE_LIMIT = N_INSTR * 40 + 200;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic       clk;
    logic       rst_n_i;
    logic       issue_valid_i;
    issue_req_t issue_i;
    logic       issue_ready_o;
    logic       wb_valid_o;
    wb_t        wb_o;

    logic [31:0] lfsr_q;
    // architectural state in issue order
    xlen_t       model_regs [NUM_REGS];
    // one expected result per rd since the scoreboard allows no more
    xlen_t       exp_data [NUM_REGS];
    logic        exp_pend [NUM_REGS];
    // execute unit that each in-flight rd was sent to
    unit_id_t    exp_unit [NUM_REGS];
    unit_mask_t  unit_busy;
    int          outstanding;
    int          n_issued;
    int          n_commits;
    int          n_data_err;
    int          n_other_err;
    logic        saw_x0;
    int          cycle_cnt;

    lic_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_i      (issue_i),
        .issue_ready_o(issue_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    // any register except x0
    function automatic reg_addr_t rand_reg();
        logic [31:0] val;
        val = rand_bits(5);
        return (val[4:0] == 5'd0) ? reg_addr_t'(1) : reg_addr_t'(val[4:0]);
    endfunction

    // dispatch goes to the lowest unit with nothing in flight
    function automatic unit_id_t lowest_free_unit();
        unit_id_t id;
        logic     hit;
        id  = '0;
        hit = 1'b0;
        for (int u = 0; u < N_UNITS; u++) begin
            if (!hit && !unit_busy[u]) begin
                id  = unit_id_t'(u);
                hit = 1'b1;
            end
        end
        return id;
    endfunction

    function automatic xlen_t ref_exec(input lic_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            OP_ADDI: return a + b;
            OP_MUL:  return a * b;
            // riscv rules give all ones for x / 0 and x for x % 0
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    // starts on a falling edge and ends on one with valid low
    task automatic issue_instr(input lic_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                               input reg_addr_t rs2, input imm_t imm);
        issue_req_t req;
        xlen_t      opa;
        xlen_t      opb;
        xlen_t      res;
        req.op        = op;
        req.rd        = rd;
        req.rs1       = rs1;
        req.rs2       = rs2;
        req.imm       = imm;
        issue_valid_i = 1'b1;
        issue_i       = req;
        // ready settles within the low phase
        #1;
        while (!issue_ready_o) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        opa = model_regs[rs1];
        opb = (op == OP_ADDI) ? {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm} : model_regs[rs2];
        res = ref_exec(op, opa, opb);
        if (rd != '0) begin
            model_regs[rd] = res;
        end
        if (exp_pend[rd]) begin
            n_other_err++;
            $display("ERROR t=%0t: second result for x%0d issued before the first returned",
                     $time, rd);
        end
        if (unit_busy == '1) begin
            n_other_err++;
            $display("ERROR t=%0t: instruction accepted while every unit was busy", $time);
        end
        exp_pend[rd]            = 1'b1;
        exp_data[rd]            = res;
        exp_unit[rd]            = lowest_free_unit();
        unit_busy[exp_unit[rd]] = 1'b1;
        outstanding++;
        n_issued++;
        @(negedge clk);
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // compare each commit with the entry queued for its rd
    always @(negedge clk) begin
        if (rst_n_i && wb_valid_o) begin
            n_commits++;
            if (wb_o.rd == '0) begin
                saw_x0 = 1'b1;
            end
            if (!exp_pend[wb_o.rd]) begin
                n_other_err++;
                $display("ERROR t=%0t: write-back to x%0d with no result expected",
                         $time, wb_o.rd);
            end else begin
                if (wb_o.data !== exp_data[wb_o.rd]) begin
                    n_data_err++;
                    $display("ERROR t=%0t wb_o.data (x%0d): expected %h, got %h",
                             $time, wb_o.rd, exp_data[wb_o.rd], wb_o.data);
                end
                if (wb_o.unit_id !== exp_unit[wb_o.rd]) begin
                    n_data_err++;
                    $display("ERROR t=%0t wb_o.unit_id (x%0d): expected %0d, got %0d",
                             $time, wb_o.rd, exp_unit[wb_o.rd], wb_o.unit_id);
                end
                unit_busy[exp_unit[wb_o.rd]] = 1'b0;
                exp_pend[wb_o.rd] = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles, %0d results outstanding",
                 CYCLE_LIMIT, outstanding);
        $display("errors: %0d data, %0d other", n_data_err, n_other_err);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        lfsr_q        = 32'heb84_3b11;
        unit_busy     = '0;
        outstanding   = 0;
        n_issued      = 0;
        n_commits     = 0;
        n_data_err    = 0;
        n_other_err   = 0;
        saw_x0        = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
            exp_data[i]   = '0;
            exp_pend[i]   = 1'b0;
            exp_unit[i]   = '0;
        end
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;

        // idle after reset
        repeat (3) begin
            @(negedge clk);
            if (wb_valid_o !== 1'b0) begin
                n_data_err++;
                $display("ERROR t=%0t wb_valid_o: expected 0, got %b", $time, wb_valid_o);
            end
            if (issue_ready_o !== 1'b1) begin
                n_data_err++;
                $display("ERROR t=%0t issue_ready_o: expected 1, got %b", $time, issue_ready_o);
            end
        end

        // load x1..x16 with some from the previous register
        for (int i = 1; i <= N_LOAD; i++) begin
            issue_instr(OP_ADDI, reg_addr_t'(i),
                        (i % 3 == 0) ? reg_addr_t'(i - 1) : reg_addr_t'(0),
                        rand_reg(), imm_t'(rand_bits(IMM_W)));
        end

        // random long ops that may finish out of order
        for (int i = 0; i < N_RAND; i++) begin
            logic [31:0] sel;
            sel = rand_bits(2);
            issue_instr((sel[1:0] == 2'd1) ? OP_DIVU : (sel[1:0] == 2'd2) ? OP_REMU : OP_MUL,
                        reg_addr_t'(32'd16 + rand_bits(4)), rand_reg(), rand_reg(), '0);
        end

        // zero divisor from x0
        issue_instr(OP_DIVU, reg_addr_t'(20), reg_addr_t'(5), reg_addr_t'(0), '0);
        issue_instr(OP_REMU, reg_addr_t'(21), reg_addr_t'(6), reg_addr_t'(0), '0);

        // each link reads the previous rd
        for (int k = 0; k < N_CHAIN; k++) begin
            lic_op_e op;
            case (k % 4)
                0:       op = OP_MUL;
                1:       op = OP_DIVU;
                2:       op = OP_REMU;
                default: op = OP_ADDI;
            endcase
            issue_instr(op, reg_addr_t'(22 + k),
                        (k == 0) ? reg_addr_t'(9) : reg_addr_t'(21 + k),
                        reg_addr_t'(10 + k), imm_t'(rand_bits(IMM_W)));
        end

        // write to x0 and then read it back
        wait_drain();
        issue_instr(OP_ADDI, reg_addr_t'(0), reg_addr_t'(3), reg_addr_t'(0), imm_t'(12'h005));
        wait_drain();
        if (!saw_x0) begin
            n_other_err++;
            $display("ERROR t=%0t: the write to x0 never reached write-back", $time);
        end
        issue_instr(OP_ADDI, reg_addr_t'(24), reg_addr_t'(0), reg_addr_t'(0), '0);
        issue_instr(OP_MUL, reg_addr_t'(25), reg_addr_t'(0), reg_addr_t'(7), '0);
        wait_drain();

        for (int i = 0; i < NUM_REGS; i++) begin
            if (exp_pend[i]) begin
                n_other_err++;
                $display("ERROR: result for x%0d never came back", i);
            end
        end
        if (n_commits != n_issued || n_issued != N_INSTR) begin
            n_other_err++;
            $display("ERROR: %0d instructions issued, %0d committed, %0d planned",
                     n_issued, n_commits, N_INSTR);
        end

        $display("errors: %0d data, %0d other, %0d commits checked",
                 n_data_err, n_other_err, n_commits);
        if (n_data_err == 0 && n_other_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
common/lic_pkg.sv
issue/gpr.sv
issue/issue_ctrl.sv
exec/exec_unit.sv
writeback/wb_arbiter.sv
verilog/lic_top.sv
tests/lic_props.sv
tests/tb_lic.sv

//--- run.sh
#!/bin/sh
# build the lic testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lic -f tb.f -o Vtb_lic || exit 1

sim_out=$(./obj_dir/Vtb_lic)
echo "$sim_out"

echo "$sim_out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
